//--- project.f
awl_pkg.sv
awl_link_if.sv
awl_offset_stage.sv
awl_memofs_stage.sv
awl_vector_stage.sv
accum_warp_looper.sv
tb_accum_warp_looper.sv

//--- Makefile
# Verilator flow for the accumulator warp looper

VERILATOR ?= verilator
TOP       ?= tb_accum_warp_looper
RTL_TOP   ?= accum_warp_looper
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
LINTFLAGS ?= --lint-only --timing

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status follows the search for the pass line
run: build
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- awl_patterns.txt
# J id base x_beg x_end y_beg y_end row_shamt x_bound y_bound
# E id addr0 addr1 addr2 addr3 lane_mask retire, and D closes a job (all hex)
# 2x2 warps, fully in bound
J 1 0100 00 02 00 02 4 20 10
E 1 0100 0101 0102 0103 f 0
E 1 0104 0105 0106 0107 f 0
E 1 0110 0111 0112 0113 f 0
E 1 0114 0115 0116 0117 f 1
D
# Last column crosses x_bound
J 2 2000 01 03 00 02 5 0a 10
E 2 2004 2005 2006 2007 f 0
E 2 2008 2009 200a 200b 3 0
E 2 2024 2025 2026 2027 f 0
E 2 2028 2029 202a 202b 3 1
D
# Empty job
J 3 3000 02 02 00 01 4 20 10
D
# Last row beyond y_bound
J 4 4000 00 01 02 05 3 10 04
E 4 4010 4011 4012 4013 f 0
E 4 4018 4019 401a 401b f 0
E 4 4020 4021 4022 4023 0 1
D
# Addresses wrap past ffff
J 5 fff4 00 03 00 02 2 ff ff
E 5 fff4 fff5 fff6 fff7 f 0
E 5 fff8 fff9 fffa fffb f 0
E 5 fffc fffd fffe ffff f 0
E 5 fff8 fff9 fffa fffb f 0
E 5 fffc fffd fffe ffff f 0
E 5 0000 0001 0002 0003 f 1
D
J 6 0a00 04 05 01 03 8 12 03
E 6 0b10 0b11 0b12 0b13 3 0
E 6 0c10 0c11 0c12 0c13 3 1
D

//--- tb_accum_warp_looper.sv
module tb_accum_warp_looper;

	localparam int CLK_HALF   = 2;
	localparam int RST_CYCLES = 4;
	localparam int WAIT_LIMIT = 200;
	localparam int DRAIN_CYCLES = 16;
	localparam int AW = awl_pkg::VSIZE * awl_pkg::ABW;

	logic                        i_clk;
	logic                        i_rst_n;
	logic                        i_job_valid;
	logic                        o_job_ready;
	logic [awl_pkg::ID_BW-1:0]   i_job_id;
	logic [awl_pkg::ABW-1:0]     i_job_base;
	logic [awl_pkg::WBW-1:0]     i_job_x_beg;
	logic [awl_pkg::WBW-1:0]     i_job_x_end;
	logic [awl_pkg::WBW-1:0]     i_job_y_beg;
	logic [awl_pkg::WBW-1:0]     i_job_y_end;
	logic [awl_pkg::SS_BW-1:0]   i_row_shamt;
	logic [awl_pkg::WBW-1:0]     i_x_bound;
	logic [awl_pkg::WBW-1:0]     i_y_bound;
	logic                        o_valid;
	logic                        i_ready;
	logic [awl_pkg::ID_BW-1:0]   o_id;
	logic [AW-1:0]               o_address;
	logic [awl_pkg::VSIZE-1:0]   o_lane_valid;
	logic                        o_retire;

	int   val_errs;
	int   other_errs;
	int   retire_seen;
	int   jobs_with_warps;
	logic aborted;

	accum_warp_looper u_dut (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_job_valid  (i_job_valid),
		.o_job_ready  (o_job_ready),
		.i_job_id     (i_job_id),
		.i_job_base   (i_job_base),
		.i_job_x_beg  (i_job_x_beg),
		.i_job_x_end  (i_job_x_end),
		.i_job_y_beg  (i_job_y_beg),
		.i_job_y_end  (i_job_y_end),
		.i_row_shamt  (i_row_shamt),
		.i_x_bound    (i_x_bound),
		.i_y_bound    (i_y_bound),
		.o_valid      (o_valid),
		.i_ready      (i_ready),
		.o_id         (o_id),
		.o_address    (o_address),
		.o_lane_valid (o_lane_valid),
		.o_retire     (o_retire)
	);

	initial begin
		i_clk = 1'b0;
		forever #CLK_HALF i_clk = ~i_clk;
	end

	// ====================
	// Job and warp handling
	// ====================
	// Every task starts by stepping to the next falling edge
	task automatic send_job(input logic [awl_pkg::ID_BW-1:0] id, input logic [awl_pkg::ABW-1:0] base,
			input logic [awl_pkg::WBW-1:0] xb, input logic [awl_pkg::WBW-1:0] xe,
			input logic [awl_pkg::WBW-1:0] yb, input logic [awl_pkg::WBW-1:0] ye,
			input logic [awl_pkg::SS_BW-1:0] shamt, input logic [awl_pkg::WBW-1:0] xbnd,
			input logic [awl_pkg::WBW-1:0] ybnd);
		int   cnt;
		logic seen;
		seen = 1'b0;
		for (cnt = 0; cnt < WAIT_LIMIT && !seen; cnt++) begin
			@(negedge i_clk);
			seen = o_job_ready;
		end
		assert (seen) else begin
			$display("Timed out waiting for the looper to take job %h", id);
			other_errs++;
			aborted = 1'b1;
		end
		if (seen) begin
			i_job_valid = 1'b1;
			i_job_id    = id;
			i_job_base  = base;
			i_job_x_beg = xb;
			i_job_x_end = xe;
			i_job_y_beg = yb;
			i_job_y_end = ye;
			i_row_shamt = shamt;
			i_x_bound   = xbnd;
			i_y_bound   = ybnd;
			// Ready was high at this edge, so the job goes in on the next rise
			@(negedge i_clk);
			i_job_valid = 1'b0;
		end
	endtask

	task automatic take_warp(input logic [awl_pkg::ID_BW-1:0] exp_id, input logic [AW-1:0] exp_addr,
			input logic [awl_pkg::VSIZE-1:0] exp_mask, input logic exp_ret);
		int   cnt;
		int   l;
		logic found;
		found = 1'b0;
		for (cnt = 0; cnt < WAIT_LIMIT && !found; cnt++) begin
			@(negedge i_clk);
			// Ready low in about a third of cycles
			i_ready = ($urandom % 3) != 0;
			found = o_valid && i_ready;
		end
		assert (found) else begin
			$display("Timed out waiting for a warp of job %h", exp_id);
			other_errs++;
			aborted = 1'b1;
		end
		if (found) begin
			assert (o_id == exp_id) else begin
				$display("Fail o_id expected %h got %h", exp_id, o_id);
				val_errs++;
			end
			assert (o_lane_valid == exp_mask) else begin
				$display("Fail o_lane_valid expected %h got %h", exp_mask, o_lane_valid);
				val_errs++;
			end
			// Addresses of masked-off lanes are don't care
			for (l = 0; l < awl_pkg::VSIZE; l++) begin
				if (exp_mask[l]) begin
					assert (o_address[l*awl_pkg::ABW +: awl_pkg::ABW]
							== exp_addr[l*awl_pkg::ABW +: awl_pkg::ABW]) else begin
						$display("Fail o_address lane %0d expected %h got %h", l,
							exp_addr[l*awl_pkg::ABW +: awl_pkg::ABW],
							o_address[l*awl_pkg::ABW +: awl_pkg::ABW]);
						val_errs++;
					end
				end
			end
			assert (o_retire == exp_ret) else begin
				$display("Fail o_retire expected %h got %h", exp_ret, o_retire);
				val_errs++;
			end
			if (o_retire) begin
				retire_seen++;
			end
		end
	endtask

	task automatic run_patterns();
		int                         fd;
		int                         n;
		int                         warps_in_job;
		string                      line;
		byte                        tag;
		logic [awl_pkg::ID_BW-1:0]  id;
		logic [awl_pkg::ABW-1:0]    base;
		logic [awl_pkg::WBW-1:0]    xb, xe, yb, ye, xbnd, ybnd;
		logic [awl_pkg::SS_BW-1:0]  shamt;
		logic [awl_pkg::ABW-1:0]    a0, a1, a2, a3;
		logic [awl_pkg::VSIZE-1:0]  mask;
		logic                       ret;
		warps_in_job = 0;
		fd = $fopen("awl_patterns.txt", "r");
		assert (fd != 0) else begin
			$display("Pattern file awl_patterns.txt could not be opened");
			other_errs++;
			aborted = 1'b1;
		end
		while (fd != 0 && !aborted && $fgets(line, fd) > 0) begin
			tag = line.getc(0);
			if (tag == "J") begin
				n = $sscanf(line, "J %h %h %h %h %h %h %h %h %h", id, base, xb, xe, yb, ye,
					shamt, xbnd, ybnd);
				assert (n == 9) else begin
					$display("A job line in the pattern file is malformed");
					other_errs++;
				end
				send_job(id, base, xb, xe, yb, ye, shamt, xbnd, ybnd);
			end else if (tag == "E") begin
				n = $sscanf(line, "E %h %h %h %h %h %h %h", id, a0, a1, a2, a3, mask, ret);
				assert (n == 7) else begin
					$display("An expect line in the pattern file is malformed");
					other_errs++;
				end
				take_warp(id, {a3, a2, a1, a0}, mask, ret);
				warps_in_job++;
			end else if (tag == "D") begin
				if (warps_in_job > 0) begin
					jobs_with_warps++;
				end
				warps_in_job = 0;
			end
		end
		if (fd != 0) begin
			$fclose(fd);
		end
	endtask

	// Nothing may come out once every expected warp is taken
	task automatic check_drained();
		int cnt;
		i_ready = 1'b1;
		for (cnt = 0; cnt < DRAIN_CYCLES; cnt++) begin
			@(negedge i_clk);
			assert (!o_valid) else begin
				$display("A warp came out after the last expected one");
				other_errs++;
			end
		end
	endtask

	// ====================
	// Main sequence
	// ====================
	initial begin
		int unsigned seed_init;
		seed_init = $urandom(38);
		i_rst_n     = 1'b0;
		i_job_valid = 1'b0;
		i_job_id    = '0;
		i_job_base  = '0;
		i_job_x_beg = '0;
		i_job_x_end = '0;
		i_job_y_beg = '0;
		i_job_y_end = '0;
		i_row_shamt = '0;
		i_x_bound   = '0;
		i_y_bound   = '0;
		i_ready     = 1'b0;
		val_errs        = 0;
		other_errs      = 0;
		retire_seen     = 0;
		jobs_with_warps = 0;
		aborted         = 1'b0;

		repeat (RST_CYCLES) @(negedge i_clk);
		i_rst_n = 1'b1;

		assert (!o_valid) else begin
			$display("Fail o_valid after reset expected %h got %h", 1'b0, o_valid);
			val_errs++;
		end
		assert (o_job_ready) else begin
			$display("Fail o_job_ready after reset expected %h got %h", 1'b1, o_job_ready);
			val_errs++;
		end

		run_patterns();
		if (!aborted) begin
			check_drained();
			assert (retire_seen == jobs_with_warps) else begin
				$display("Fail o_retire count expected %h got %h", jobs_with_warps, retire_seen);
				val_errs++;
			end
		end

		$display("Errors: %0d wrong values, %0d other failures", val_errs, other_errs);
		if (val_errs == 0 && other_errs == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

//--- accum_warp_looper.sv
module accum_warp_looper (
	input  logic                                   i_clk,
	input  logic                                   i_rst_n,
	// Job request
	input  logic                                   i_job_valid,
	output logic                                   o_job_ready,
	input  logic [awl_pkg::ID_BW-1:0]              i_job_id,
	input  logic [awl_pkg::ABW-1:0]                i_job_base,
	input  logic [awl_pkg::WBW-1:0]                i_job_x_beg,
	input  logic [awl_pkg::WBW-1:0]                i_job_x_end,
	input  logic [awl_pkg::WBW-1:0]                i_job_y_beg,
	input  logic [awl_pkg::WBW-1:0]                i_job_y_end,
	// Static configuration
	input  logic [awl_pkg::SS_BW-1:0]              i_row_shamt,
	input  logic [awl_pkg::WBW-1:0]                i_x_bound,
	input  logic [awl_pkg::WBW-1:0]                i_y_bound,
	// Warp addresses
	output logic                                   o_valid,
	input  logic                                   i_ready,
	output logic [awl_pkg::ID_BW-1:0]              o_id,
	output logic [awl_pkg::VSIZE*awl_pkg::ABW-1:0] o_address,
	output logic [awl_pkg::VSIZE-1:0]              o_lane_valid,
	output logic                                   o_retire
);

	// ====================
	// Links
	// ====================
	awl_link_if #(.beat_t(awl_pkg::ofs_beat_t))  u_ofs_link ();
	awl_link_if #(.beat_t(awl_pkg::mofs_beat_t)) u_mofs_link ();

	// ====================
	// Stages
	// ====================
	awl_offset_stage u_ofs (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_job_valid (i_job_valid),
		.o_job_ready (o_job_ready),
		.i_job_id    (i_job_id),
		.i_job_x_beg (i_job_x_beg),
		.i_job_x_end (i_job_x_end),
		.i_job_y_beg (i_job_y_beg),
		.i_job_y_end (i_job_y_end),
		.dst         (u_ofs_link.src)
	);

	// Base is sampled per warp in this stage
	awl_memofs_stage u_mofs (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_job_base  (i_job_base),
		.i_row_shamt (i_row_shamt),
		.i_y_bound   (i_y_bound),
		.src         (u_ofs_link.dst),
		.dst         (u_mofs_link.src)
	);

	awl_vector_stage u_vec (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_x_bound    (i_x_bound),
		.src          (u_mofs_link.dst),
		.o_valid      (o_valid),
		.i_ready      (i_ready),
		.o_id         (o_id),
		.o_address    (o_address),
		.o_lane_valid (o_lane_valid),
		.o_retire     (o_retire)
	);

endmodule

//--- awl_vector_stage.sv
module awl_vector_stage (
	input  logic                                        i_clk,
	input  logic                                        i_rst_n,
	input  logic [awl_pkg::WBW-1:0]                     i_x_bound,
	awl_link_if.dst                                     src,
	output logic                                        o_valid,
	input  logic                                        i_ready,
	output logic [awl_pkg::ID_BW-1:0]                   o_id,
	output logic [awl_pkg::VSIZE*awl_pkg::ABW-1:0]      o_address,
	output logic [awl_pkg::VSIZE-1:0]                   o_lane_valid,
	output logic                                        o_retire
);

	// ====================
	// Signals
	// ====================
	awl_pkg::mofs_beat_t                           in_beat;
	logic [awl_pkg::VSIZE*awl_pkg::ABW-1:0]        lane_addr;
	logic [awl_pkg::VSIZE-1:0]                     lane_ok;
	logic [awl_pkg::WBW+awl_pkg::VSIZE_BW-1:0]     bound_ext;
	logic                                          in_xfer;

	logic                                          valid_q;
	logic                                          retire_q;
	logic [awl_pkg::ID_BW-1:0]                     id_q;
	logic [awl_pkg::VSIZE*awl_pkg::ABW-1:0]        addr_q;
	logic [awl_pkg::VSIZE-1:0]                     mask_q;

	assign in_beat = src.data;
	assign bound_ext = {{awl_pkg::VSIZE_BW{1'b0}}, i_x_bound};

	// ====================
	// Lane expansion
	// ====================
	always_comb begin
		logic [awl_pkg::VSIZE_BW-1:0]             lane;
		logic [awl_pkg::WBW+awl_pkg::VSIZE_BW-1:0] elem;
		for (int l = 0; l < awl_pkg::VSIZE; l++) begin
			lane = l[awl_pkg::VSIZE_BW-1:0];
			// Element index is x*VSIZE + l
			elem = {in_beat.x, lane};
			lane_addr[l*awl_pkg::ABW +: awl_pkg::ABW] = in_beat.row_addr
				+ {{(awl_pkg::ABW - awl_pkg::VSIZE_BW){1'b0}}, lane};
			lane_ok[l] = in_beat.row_ok && (elem < bound_ext);
		end
	end

	// ====================
	// Output register
	// ====================
	assign src.ready = !valid_q || i_ready;
	assign in_xfer = src.valid && src.ready;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			valid_q <= 1'b0;
		end else if (src.ready) begin
			valid_q <= src.valid;
		end
	end

	// Retire is loaded with its warp and dropped once the warp leaves
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			retire_q <= 1'b0;
		end else if (in_xfer) begin
			retire_q <= in_beat.last;
		end else if (i_ready) begin
			retire_q <= 1'b0;
		end
	end

	always_ff @(posedge i_clk) begin
		if (in_xfer) begin
			id_q   <= in_beat.id;
			addr_q <= lane_addr;
			mask_q <= lane_ok;
		end
	end

	assign o_valid      = valid_q;
	assign o_id         = id_q;
	assign o_address    = addr_q;
	assign o_lane_valid = mask_q;
	assign o_retire     = retire_q;

	a_retire_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_retire |-> o_valid);

endmodule

//--- awl_memofs_stage.sv
module awl_memofs_stage (
	input  logic                      i_clk,
	input  logic                      i_rst_n,
	input  logic [awl_pkg::ABW-1:0]   i_job_base,
	input  logic [awl_pkg::SS_BW-1:0] i_row_shamt,
	input  logic [awl_pkg::WBW-1:0]   i_y_bound,
	awl_link_if.dst                   src,
	awl_link_if.src                   dst
);

	// ====================
	// Signals
	// ====================
	awl_pkg::ofs_beat_t      in_beat;
	awl_pkg::mofs_beat_t     next_beat;
	awl_pkg::mofs_beat_t     beat_q;
	logic                    valid_q;
	logic                    in_xfer;

	logic [awl_pkg::ABW-1:0] x_ext;
	logic [awl_pkg::ABW-1:0] y_ext;
	logic [awl_pkg::ABW-1:0] row_ofs;
	logic [awl_pkg::ABW-1:0] col_ofs;

	assign in_beat = src.data;

	// ====================
	// Row address
	// ====================
	assign x_ext = {{(awl_pkg::ABW - awl_pkg::WBW){1'b0}}, in_beat.x};
	assign y_ext = {{(awl_pkg::ABW - awl_pkg::WBW){1'b0}}, in_beat.y};
	// Rows are a power of two apart
	assign row_ofs = y_ext << i_row_shamt;
	// One warp covers VSIZE consecutive words
	assign col_ofs = x_ext << awl_pkg::VSIZE_BW;

	always_comb begin
		next_beat.id       = in_beat.id;
		next_beat.x        = in_beat.x;
		// Wraps at 2^ABW
		next_beat.row_addr = i_job_base + row_ofs + col_ofs;
		next_beat.row_ok   = in_beat.y < i_y_bound;
		next_beat.last     = in_beat.last;
	end

	// ====================
	// Pipeline register
	// ====================
	assign src.ready = !valid_q || dst.ready;
	assign in_xfer = src.valid && src.ready;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			valid_q <= 1'b0;
		end else if (src.ready) begin
			valid_q <= src.valid;
		end
	end

	always_ff @(posedge i_clk) begin
		if (in_xfer) begin
			beat_q <= next_beat;
		end
	end

	assign dst.valid = valid_q;
	assign dst.data  = beat_q;

	// Upstream keeps its beat steady while this stage stalls it
	a_src_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		src.valid && !src.ready |=> src.valid && $stable(src.data));

endmodule

//--- awl_offset_stage.sv
module awl_offset_stage (
	input  logic                      i_clk,
	input  logic                      i_rst_n,
	input  logic                      i_job_valid,
	output logic                      o_job_ready,
	input  logic [awl_pkg::ID_BW-1:0] i_job_id,
	input  logic [awl_pkg::WBW-1:0]   i_job_x_beg,
	input  logic [awl_pkg::WBW-1:0]   i_job_x_end,
	input  logic [awl_pkg::WBW-1:0]   i_job_y_beg,
	input  logic [awl_pkg::WBW-1:0]   i_job_y_end,
	awl_link_if.src                   dst
);

	// ====================
	// State
	// ====================
	logic                      busy;
	logic [awl_pkg::WBW-1:0]   cur_x;
	logic [awl_pkg::WBW-1:0]   cur_y;
	logic [awl_pkg::WBW-1:0]   x_beg_q;
	logic [awl_pkg::WBW-1:0]   x_end_q;
	logic [awl_pkg::WBW-1:0]   y_beg_q;
	logic [awl_pkg::WBW-1:0]   y_end_q;
	logic [awl_pkg::ID_BW-1:0] id_q;

	logic                      job_acc;
	logic                      job_nonempty;
	logic                      x_at_end;
	logic                      y_at_end;
	logic                      beat_last;
	logic                      beat_xfer;
	awl_pkg::ofs_beat_t        beat;

	// ====================
	// Control
	// ====================
	assign o_job_ready = !busy;
	assign job_acc = i_job_valid && !busy;
	// Empty rectangles are swallowed without a single beat
	assign job_nonempty = (i_job_x_beg < i_job_x_end) && (i_job_y_beg < i_job_y_end);

	assign x_at_end = cur_x == x_end_q - 1;
	assign y_at_end = cur_y == y_end_q - 1;
	assign beat_last = x_at_end && y_at_end;
	assign beat_xfer = dst.valid && dst.ready;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			busy <= 1'b0;
		end else if (job_acc) begin
			busy <= job_nonempty;
		end else if (beat_xfer && beat_last) begin
			busy <= 1'b0;
		end
	end

	// Row-major walk, columns wrap back to x_beg at the end of a row
	always_ff @(posedge i_clk) begin
		if (job_acc) begin
			id_q    <= i_job_id;
			x_beg_q <= i_job_x_beg;
			x_end_q <= i_job_x_end;
			y_beg_q <= i_job_y_beg;
			y_end_q <= i_job_y_end;
			cur_x   <= i_job_x_beg;
			cur_y   <= i_job_y_beg;
		end else if (beat_xfer && !beat_last) begin
			if (x_at_end) begin
				cur_x <= x_beg_q;
				cur_y <= cur_y + 1;
			end else begin
				cur_x <= cur_x + 1;
			end
		end
	end

	// ====================
	// Output beat
	// ====================
	always_comb begin
		beat.id   = id_q;
		beat.x    = cur_x;
		beat.y    = cur_y;
		beat.last = beat_last;
	end

	assign dst.valid = busy;
	assign dst.data  = beat;

	// Position never leaves the latched rectangle
	a_pos_in_bounds: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		busy |-> (cur_x >= x_beg_q && cur_x < x_end_q && cur_y >= y_beg_q && cur_y < y_end_q));

endmodule

//--- awl_link_if.sv
interface awl_link_if #(
	parameter type beat_t = logic
);

	logic  valid;
	logic  ready;
	beat_t data;

	// Producer side of a link
	modport src (
		output valid,
		output data,
		input  ready
	);

	// Consumer side of a link
	modport dst (
		input  valid,
		input  data,
		output ready
	);

endinterface

//--- awl_pkg.sv
package awl_pkg;

	// ====================
	// Widths
	// ====================
	// Warp coordinate
	localparam int WBW = 8;
	// Address word
	localparam int ABW = 16;
	// Lanes per warp and its log2
	localparam int VSIZE = 4;
	localparam int VSIZE_BW = 2;
	// Row pitch given as a left shift
	localparam int SS_BW = 4;
	localparam int ID_BW = 4;

	// ====================
	// Stage beats
	// ====================
	// Offset stage to memory-offset stage
	typedef struct packed {
		logic [ID_BW-1:0] id;
		logic [WBW-1:0]   x;
		logic [WBW-1:0]   y;
		logic             last;
	} ofs_beat_t;

	// Memory-offset stage to vector stage
	typedef struct packed {
		logic [ID_BW-1:0] id;
		logic [WBW-1:0]   x;
		logic [ABW-1:0]   row_addr;
		logic             row_ok;
		logic             last;
	} mofs_beat_t;

endpackage
